// File: cpu_mem_config.svh
`ifndef CPU_MEM_CONFIG_SVH
`define CPU_MEM_CONFIG_SVH

// Data RAM size in 32-bit words
`define CPU_MEM_DEPTH_WORDS 256

// Word-address width, so byte addresses above bit 9 are out of range
`define CPU_MEM_ADDR_BITS 8

// Extra access-phase cycles before the RAM raises pready
`define CPU_MEM_WAIT_STATES 2

`endif

// File: cpu_mem_pkg.sv
package cpu_mem_pkg;

    typedef logic [31:0] word_t;      // Data or byte address
    typedef logic [4:0]  reg_idx_t;   // Destination register index
    typedef logic [3:0]  byte_en_t;   // One strobe per byte lane

    typedef enum logic [1:0]
    {
        op_none,
        op_load,
        op_store
    } mem_op_t;

    typedef enum logic [1:0]
    {
        size_byte,
        size_half,
        size_word
    } mem_size_t;

    // Memory stage controller states
    typedef enum logic [1:0]
    {
        st_idle,
        st_setup,
        st_access,
        st_done
    } ctrl_state_t;

    // Execute-to-memory packet; addr also carries the ALU result for op_none
    typedef struct packed
    {
        mem_op_t   op;
        mem_size_t size;
        logic      sign_ext;
        word_t     addr;
        word_t     store_data;
        reg_idx_t  rd;
        logic      reg_write;
    } ex_mem_t;

    // Memory-to-writeback packet
    typedef struct packed
    {
        logic     reg_write;
        reg_idx_t rd;
        word_t    result;
        logic     mem_err;     // Out-of-range access
    } mem_wb_t;

endpackage

// File: store_align.sv
`timescale 1ns/1ps

module store_align (
    input  cpu_mem_pkg::mem_size_t size,
    input  logic [1:0]             byte_off,
    input  cpu_mem_pkg::word_t     store_data,
    output cpu_mem_pkg::word_t     pwdata,
    output cpu_mem_pkg::byte_en_t  pstrb
);

    // Data is replicated so every lane holds it; strobes pick the lanes
    always_comb
    begin
        case (size)
            cpu_mem_pkg::size_byte:
            begin
                pwdata = {4{store_data[7:0]}};
                pstrb  = 4'b0001 << byte_off;
            end
            cpu_mem_pkg::size_half:
            begin
                pwdata = {2{store_data[15:0]}};
                pstrb  = byte_off[1] ? 4'b1100 : 4'b0011;   // Odd offsets round down
            end
            default:
            begin
                pwdata = store_data;
                pstrb  = 4'b1111;
            end
        endcase
    end

endmodule

// File: load_extract.sv
`timescale 1ns/1ps

module load_extract (
    input  cpu_mem_pkg::mem_size_t size,
    input  logic [1:0]             byte_off,
    input  logic                   sign_ext,
    input  cpu_mem_pkg::word_t     rdata,
    output cpu_mem_pkg::word_t     result
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    always_comb
    begin
        case (byte_off)
            2'd0:    sel_byte = rdata[7:0];
            2'd1:    sel_byte = rdata[15:8];
            2'd2:    sel_byte = rdata[23:16];
            default: sel_byte = rdata[31:24];
        endcase
    end

    assign sel_half = byte_off[1] ? rdata[31:16] : rdata[15:0];   // Offset 1 or 3 rounds down

    always_comb
    begin
        case (size)
            cpu_mem_pkg::size_byte:
                result = {{24{sign_ext && sel_byte[7]}}, sel_byte};
            cpu_mem_pkg::size_half:
                result = {{16{sign_ext && sel_half[15]}}, sel_half};
            default:
                result = rdata;
        endcase
    end

endmodule

// File: mem_access_ctrl.sv
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  cpu_mem_pkg::ex_mem_t    in_pkt,
    input  cpu_mem_pkg::word_t      prdata_ext,
    input  logic                    pready,
    input  logic                    pslverr,
    output logic                    in_ready,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output cpu_mem_pkg::word_t      paddr,
    output cpu_mem_pkg::ex_mem_t    pkt_q,
    output logic                    wb_valid,
    output cpu_mem_pkg::mem_wb_t    wb_pkt
);

    cpu_mem_pkg::ctrl_state_t state;
    logic                     accept;
    logic                     xfer_done;
    logic                     is_load;

    assign in_ready  = (state == cpu_mem_pkg::st_idle);
    assign accept    = in_valid && in_ready;
    assign psel      = (state == cpu_mem_pkg::st_setup) || (state == cpu_mem_pkg::st_access);
    assign penable   = (state == cpu_mem_pkg::st_access);
    assign pwrite    = psel && (pkt_q.op == cpu_mem_pkg::op_store);
    assign paddr     = {pkt_q.addr[31:2], 2'b00};   // Lanes come from the strobes
    assign xfer_done = penable && pready;
    assign is_load   = (pkt_q.op == cpu_mem_pkg::op_load);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state    <= cpu_mem_pkg::st_idle;
            wb_valid <= 1'b0;
        end
        else
        begin
            wb_valid <= 1'b0;
            case (state)
                cpu_mem_pkg::st_idle:
                begin
                    if (accept)
                    begin
                        if (in_pkt.op == cpu_mem_pkg::op_none)
                            wb_valid <= 1'b1;               // Pass-through, no stall
                        else
                            state <= cpu_mem_pkg::st_setup;
                    end
                end
                cpu_mem_pkg::st_setup:
                    state <= cpu_mem_pkg::st_access;
                cpu_mem_pkg::st_access:
                begin
                    if (pready)
                        state <= cpu_mem_pkg::st_done;      // Hold until the RAM answers
                end
                cpu_mem_pkg::st_done:
                begin
                    wb_valid <= 1'b1;
                    state    <= cpu_mem_pkg::st_idle;
                end
                default:
                    state <= cpu_mem_pkg::st_idle;
            endcase
        end
    end

    // Packet capture and write-back payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            pkt_q <= in_pkt;
            if (in_pkt.op == cpu_mem_pkg::op_none)
            begin
                wb_pkt.reg_write <= in_pkt.reg_write;
                wb_pkt.rd        <= in_pkt.rd;
                wb_pkt.result    <= in_pkt.addr;       // ALU result
                wb_pkt.mem_err   <= 1'b0;
            end
        end
        if (xfer_done)
        begin
            wb_pkt.reg_write <= is_load && pkt_q.reg_write;  // Stores never write a register
            wb_pkt.rd        <= pkt_q.rd;
            wb_pkt.result    <= is_load ? prdata_ext : '0;
            wb_pkt.mem_err   <= pslverr;
        end
    end

endmodule

// File: data_sram_apb.sv
`timescale 1ns/1ps

`include "cpu_mem_config.svh"

module data_sram_apb (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  cpu_mem_pkg::word_t    paddr,
    input  cpu_mem_pkg::word_t    pwdata,
    input  cpu_mem_pkg::byte_en_t pstrb,
    output cpu_mem_pkg::word_t    prdata,
    output logic                  pready,
    output logic                  pslverr
);

    localparam int CNT_W = $clog2(`CPU_MEM_WAIT_STATES + 2);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CPU_MEM_WAIT_STATES);

    cpu_mem_pkg::word_t             mem [`CPU_MEM_DEPTH_WORDS];
    logic [CNT_W-1:0]               wait_cnt;
    logic [`CPU_MEM_ADDR_BITS-1:0]  row;
    logic                           out_of_range;
    logic                           access;

    assign row          = paddr[`CPU_MEM_ADDR_BITS+1:2];
    assign out_of_range = |paddr[31:`CPU_MEM_ADDR_BITS+2];
    assign access       = psel && penable;
    assign pready       = access && (wait_cnt == CNT_LAST);
    assign pslverr      = pready && out_of_range;
    assign prdata       = out_of_range ? '0 : mem[row];

    // Wait-state counter, cleared at the end of every transfer
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            wait_cnt <= '0;
        else if (access && !pready)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CPU_MEM_DEPTH_WORDS; i++)
                mem[i] <= '0;
        end
        else if (pready && pwrite && !out_of_range)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (pstrb[b])
                    mem[row][8*b +: 8] <= pwdata[8*b +: 8];   // Strobed lanes only
            end
        end
    end

endmodule

// File: mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  cpu_mem_pkg::ex_mem_t in_pkt,
    output logic                 in_ready,
    output logic                 wb_valid,
    output cpu_mem_pkg::mem_wb_t wb_pkt
);

    cpu_mem_pkg::ex_mem_t  pkt_q;
    cpu_mem_pkg::word_t    paddr;
    cpu_mem_pkg::word_t    pwdata;
    cpu_mem_pkg::word_t    prdata;
    cpu_mem_pkg::word_t    prdata_ext;
    cpu_mem_pkg::byte_en_t pstrb;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic                  pready;
    logic                  pslverr;

    mem_access_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_pkt     (in_pkt),
        .prdata_ext (prdata_ext),
        .pready     (pready),
        .pslverr    (pslverr),
        .in_ready   (in_ready),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pkt_q      (pkt_q),
        .wb_valid   (wb_valid),
        .wb_pkt     (wb_pkt)
    );

    // Byte offset comes from the captured packet, steady for the whole transfer
    store_align u_store_align (
        .size       (pkt_q.size),
        .byte_off   (pkt_q.addr[1:0]),
        .store_data (pkt_q.store_data),
        .pwdata     (pwdata),
        .pstrb      (pstrb)
    );

    load_extract u_load_extract (
        .size     (pkt_q.size),
        .byte_off (pkt_q.addr[1:0]),
        .sign_ext (pkt_q.sign_ext),
        .rdata    (prdata),
        .result   (prdata_ext)
    );

    data_sram_apb u_sram (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

endmodule

// File: mem_stage_properties.sv
`timescale 1ns/1ps

module mem_stage_properties (
    input logic               clk,
    input logic               rst,
    input logic               psel,
    input logic               penable,
    input cpu_mem_pkg::word_t paddr,
    input logic               wb_valid,
    input logic               in_ready
);

    // Address held from setup through the last access cycle
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> $stable(paddr))
        else $error("paddr changed during the APB access phase");

    enable_after_setup: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> $past(psel && !penable))
        else $error("penable rose without a preceding setup cycle");

    wb_not_during_xfer: assert property (@(posedge clk) disable iff (rst)
        !(wb_valid && psel))
        else $error("wb_valid high while an APB transfer is running");

    // Stage stalls upstream for the whole transfer
    stall_on_xfer: assert property (@(posedge clk) disable iff (rst)
        psel |-> !in_ready)
        else $error("in_ready high while psel is high");

endmodule

bind mem_stage mem_stage_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .paddr    (paddr),
    .wb_valid (wb_valid),
    .in_ready (in_ready)
);

// File: tb_mem_stage.sv
`timescale 1ns/1ps

`include "cpu_mem_config.svh"

module tb_mem_stage;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 in_valid;
    cpu_mem_pkg::ex_mem_t in_pkt;
    logic                 in_ready;
    logic                 wb_valid;
    cpu_mem_pkg::mem_wb_t wb_pkt;

    cpu_mem_pkg::ex_mem_t stim_q[$];     // Packets in file order
    cpu_mem_pkg::mem_wb_t exp_q[$];      // Expected write-back, same order
    int                   due_q[$];      // Cycle each accepted packet must come back in
    int                   num_vec = 0;
    int                   received = 0;
    int                   cyc = 0;
    logic                 loaded = 1'b0;

    mem_stage mem_stage_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_pkt   (in_pkt),
        .in_ready (in_ready),
        .wb_valid (wb_valid),
        .wb_pkt   (wb_pkt)
    );

    always #2 clk = ~clk;   // 4 ns period

    always @(posedge clk)
        cyc = cyc + 1;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Run stopped on the first error");
    endtask

    // Edges from acceptance to the write-back pulse
    function automatic int wb_latency(input cpu_mem_pkg::mem_op_t op);
        return (op == cpu_mem_pkg::op_none) ? 1 : 4 + `CPU_MEM_WAIT_STATES;
    endfunction

    task automatic load_vectors();
        int                   fd;
        int                   n;
        string                line;
        logic [31:0]          f [9];
        cpu_mem_pkg::ex_mem_t p;
        cpu_mem_pkg::mem_wb_t e;
        fd = $fopen("mem_stage_input.txt", "r");
        if (fd == 0)
            fail_run("Cannot open mem_stage_input.txt for reading");
        while ($fgets(line, fd) != 0)
        begin
            if (line.len() < 3 || line.substr(0, 1) == "//")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
            assert (n == 9)
                else fail_run($sformatf("Malformed vector line: %s", line));
            p.op         = cpu_mem_pkg::mem_op_t'(f[0][1:0]);
            p.size       = cpu_mem_pkg::mem_size_t'(f[1][1:0]);
            p.sign_ext   = f[2][0];
            p.addr       = f[3];
            p.store_data = f[4];
            p.rd         = f[5][4:0];
            p.reg_write  = f[6][0];
            e.reg_write  = (p.op == cpu_mem_pkg::op_store) ? 1'b0 : p.reg_write;
            e.rd         = p.rd;
            e.result     = f[7];
            e.mem_err    = f[8][0];
            stim_q.push_back(p);
            exp_q.push_back(e);
        end
        $fclose(fd);
        num_vec = stim_q.size();
        loaded  = 1'b1;
    endtask

    // Last eight packets go back to back to exercise the stall path
    task automatic drive_packets();
        int gap;
        for (int i = 0; i < num_vec; i++)
        begin
            gap = (i >= num_vec - 8) ? 0 : int'($urandom % 4);
            if (gap > 0)
            begin
                in_valid = 1'b0;
                repeat (gap) @(negedge clk);
            end
            in_valid = 1'b1;
            in_pkt   = stim_q[i];
            while (!in_ready)
                @(negedge clk);
            due_q.push_back(cyc + wb_latency(stim_q[i].op));
            @(negedge clk);   // Transfer on the rising edge in between
        end
        in_valid = 1'b0;
    endtask

    task automatic check_wb();
        cpu_mem_pkg::mem_wb_t e;
        int                   due;
        assert (due_q.size() > 0)
            else fail_run("Write-back packet arrived with no packet outstanding");
        e   = exp_q.pop_front();
        due = due_q.pop_front();
        assert (cyc == due)
            else fail_run($sformatf("Mismatch at %0t: packet %0d wb_valid in cycle %0d expected %0d",
                                    $time, received, cyc, due));
        assert (in_ready)
            else fail_run($sformatf("Mismatch at %0t: packet %0d in_ready low with wb_valid",
                                    $time, received));
        assert (wb_pkt.reg_write == e.reg_write)
            else fail_run($sformatf("Mismatch at %0t: packet %0d reg_write got %0b expected %0b",
                                    $time, received, wb_pkt.reg_write, e.reg_write));
        assert (wb_pkt.rd == e.rd)
            else fail_run($sformatf("Mismatch at %0t: packet %0d rd got %0d expected %0d",
                                    $time, received, wb_pkt.rd, e.rd));
        assert (wb_pkt.result == e.result)
            else fail_run($sformatf("Mismatch at %0t: packet %0d result got %h expected %h",
                                    $time, received, wb_pkt.result, e.result));
        assert (wb_pkt.mem_err == e.mem_err)
            else fail_run($sformatf("Mismatch at %0t: packet %0d mem_err got %0b expected %0b",
                                    $time, received, wb_pkt.mem_err, e.mem_err));
        received++;
    endtask

    always @(negedge clk)
    begin
        if (!rst && wb_valid)
            check_wb();
    end

    // Watchdog
    initial
    begin
        wait (loaded);
        repeat (num_vec * 12 + 100) @(posedge clk);
        fail_run("Timeout: not every packet came back from the memory stage");
    end

    initial
    begin
        rst      = 1'b1;
        in_valid = 1'b0;
        in_pkt   = '0;
        void'($urandom(32'hdd01_7bfa));
        load_vectors();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        assert (in_ready && !wb_valid)
            else fail_run("After reset in_ready is low or wb_valid is high");
        drive_packets();
        wait (received == num_vec);
        repeat (10) @(negedge clk);   // Room for a late duplicate to show up
        if (received == num_vec && exp_q.size() == 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
            fail_run("Write-back count does not match the accepted packets");
    end

endmodule

// File: mem_stage_input.txt
// op size sign_ext addr store_data rd reg_write exp_result exp_err (all hex)
// op: 0 none 1 load 2 store; size: 0 byte 1 half 2 word
2 2 0 00000010 cafe1234 05 1 00000000 0
1 2 0 00000010 00000000 05 1 cafe1234 0
2 2 0 000003fc 89abcdef 1f 0 00000000 0
1 2 0 000003fc 00000000 1f 1 89abcdef 0
1 2 0 000003fc 00000000 0a 0 89abcdef 0
// Byte and half merges
2 2 0 00000020 11223344 01 0 00000000 0
2 0 0 00000020 000000aa 01 0 00000000 0
2 0 0 00000021 000000bb 01 0 00000000 0
2 0 0 00000022 ffffffcc 01 0 00000000 0
2 0 0 00000023 000000dd 01 0 00000000 0
1 2 0 00000020 00000000 02 1 ddccbbaa 0
2 2 0 00000030 55667788 01 0 00000000 0
2 1 0 00000030 0000beef 01 0 00000000 0
1 2 0 00000030 00000000 03 1 5566beef 0
2 1 0 00000032 1234f00d 01 0 00000000 0
2 1 0 00000033 0000a5a5 01 0 00000000 0
2 1 0 00000031 00000102 01 0 00000000 0
1 2 0 00000030 00000000 04 1 a5a50102 0
// Sub-word loads
1 0 0 00000020 00000000 06 1 000000aa 0
1 0 1 00000020 00000000 06 1 ffffffaa 0
1 0 1 00000021 00000000 06 1 ffffffbb 0
1 0 0 00000022 00000000 06 1 000000cc 0
1 0 1 00000023 00000000 06 1 ffffffdd 0
1 0 1 00000031 00000000 07 1 00000001 0
1 1 1 00000030 00000000 07 1 00000102 0
1 1 1 00000032 00000000 07 1 ffffa5a5 0
1 1 0 00000032 00000000 07 1 0000a5a5 0
1 1 1 00000022 00000000 08 1 ffffddcc 0
1 1 0 00000023 00000000 08 1 0000ddcc 0
1 1 1 00000021 00000000 08 1 ffffbbaa 0
// Pass-through and out-of-range
0 0 0 deadbeef 00000000 07 1 deadbeef 0
0 2 1 00000400 12345678 1e 0 00000400 0
0 0 0 0000abcd 00000000 03 1 0000abcd 0
2 2 0 00000000 0badf00d 02 0 00000000 0
2 2 0 00000400 ffffffff 02 0 00000000 1
2 0 0 80000001 000000ee 02 0 00000000 1
1 2 0 00000404 00000000 08 1 00000000 1
1 0 1 fffffffc 00000000 09 1 00000000 1
1 2 0 00000000 00000000 0a 1 0badf00d 0
0 0 0 00000011 00000000 11 1 00000011 0
1 2 0 00000010 00000000 12 1 cafe1234 0
0 0 0 00000022 00000000 13 1 00000022 0
1 0 1 00000013 00000000 14 1 ffffffca 0
2 1 0 00000012 00007777 15 1 00000000 0
1 2 0 00000010 00000000 16 1 77771234 0

// File: vlog.f
+incdir+.
cpu_mem_pkg.sv
store_align.sv
load_extract.sv
mem_access_ctrl.sv
data_sram_apb.sv
mem_stage.sv
mem_stage_properties.sv
tb_mem_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory stage testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_mem_stage \
    -o sim_mem_stage > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_mem_stage > sim.log 2>&1
cat sim.log

grep -q "Checks failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
